// ==== hw/l1i_pkg.sv ====
package l1i_pkg;

    // fetch address split: tag | index | offset
    localparam int TAG_BITS    = 21;
    localparam int INDEX_BITS  = 5;
    localparam int OFFSET_BITS = 6;

    // line address as seen by the L2
    localparam int L2_TAG_BITS   = 18;
    localparam int L2_INDEX_BITS = 8;
    localparam int L2_ADDR_BITS  = L2_TAG_BITS + L2_INDEX_BITS;

    localparam int WORDS_PER_LINE = 16;
    localparam int LINE_BITS      = WORDS_PER_LINE * 32;

    // every L2 word is its byte address xor this
    localparam logic [31:0] L2_PATTERN = 32'h5a3c_0f96;

    typedef enum logic [1:0]
    {
        s_idle     = 2'b00,
        s_compare  = 2'b01,
        s_allocate = 2'b11
    } ctrl_state_t;

endpackage

// ==== hw/l1i_controller.sv ====
`timescale 1ns/100ps

module l1i_controller
    import l1i_pkg::*;
(
    input  logic                     clk,
    input  logic                     nrst,
    input  logic [TAG_BITS-1:0]      fetch_tag,
    input  logic [INDEX_BITS-1:0]    fetch_index,
    input  logic                     fetch_read,
    input  logic                     flush,
    input  logic                     ready_l2,
    output logic                     stall,
    output logic                     refill,
    output logic                     read_l2,
    output logic [L2_INDEX_BITS-1:0] l2_index,
    output logic [L2_TAG_BITS-1:0]   l2_tag,
    output logic                     way,
    output logic                     hit,
    output logic                     miss
);

    localparam int ENTRIES = 2 ** (INDEX_BITS + 1);

    ctrl_state_t state, next_state;

    logic [TAG_BITS-1:0]        tag_arr [ENTRIES];
    logic [ENTRIES-1:0]         valid;
    logic [2**INDEX_BITS-1:0]   lru;        // way to replace next, per set

    logic way_reg;
    logic hit_reg;
    logic miss_reg;
    logic refill_reg;
    logic read_reg;
    logic match_0;
    logic match_1;
    logic lookup;
    logic fill;

    assign match_0 = valid[{fetch_index, 1'b0}] && (tag_arr[{fetch_index, 1'b0}] == fetch_tag);
    assign match_1 = valid[{fetch_index, 1'b1}] && (tag_arr[{fetch_index, 1'b1}] == fetch_tag);

    // first compare cycle, before hit or miss is known
    assign lookup = (state == s_compare) && !hit_reg && !miss_reg;
    assign fill   = (state == s_allocate) && ready_l2;

    assign stall    = (state != s_idle);
    assign refill   = refill_reg;
    assign read_l2  = read_reg;
    assign way      = way_reg;
    assign hit      = hit_reg;
    assign miss     = miss_reg;
    assign l2_tag   = fetch_tag[TAG_BITS-1 -: L2_TAG_BITS];
    assign l2_index = {fetch_tag[TAG_BITS-L2_TAG_BITS-1:0], fetch_index};

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
            state <= s_idle;
        else
            state <= next_state;
    end

    always_comb
    begin
        next_state = state;
        case (state)
            s_idle:     next_state = fetch_read ? s_compare : s_idle;
            s_compare:  next_state = hit_reg ? s_idle : (miss_reg ? s_allocate : s_compare);
            s_allocate: next_state = ready_l2 ? s_compare : s_allocate;
            default:    next_state = s_idle;
        endcase
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            hit_reg    <= 1'b0;
            miss_reg   <= 1'b0;
            refill_reg <= 1'b0;
            read_reg   <= 1'b0;
        end
        else
        begin
            hit_reg    <= lookup && (match_0 || match_1);
            miss_reg   <= lookup && !(match_0 || match_1);
            refill_reg <= fill;                              // data array writes next cycle
            read_reg   <= (state == s_allocate) && !ready_l2;
        end
    end

    // matching way, else invalid way, else lru way
    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
            way_reg <= 1'b0;
        else if (lookup)
        begin
            if (match_0)
                way_reg <= 1'b0;
            else if (match_1)
                way_reg <= 1'b1;
            else if (!valid[{fetch_index, 1'b0}])
                way_reg <= 1'b0;
            else if (!valid[{fetch_index, 1'b1}])
                way_reg <= 1'b1;
            else
                way_reg <= lru[fetch_index];
        end
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
            lru <= '0;
        else if ((state == s_compare) && hit_reg)
            lru[fetch_index] <= !way_reg;
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
            valid <= '0;
        else if ((state == s_idle) && flush)
            valid <= '0;
        else if (fill)
            valid[{fetch_index, way_reg}] <= 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (fill)
            tag_arr[{fetch_index, way_reg}] <= fetch_tag;
    end

    // no l2 traffic at all while idle
    a_no_read_idle: assert property (@(posedge clk) disable iff (!nrst)
        (state == s_idle) |-> (!read_l2 && !ready_l2));

    // reply only comes back to a pending request
    a_refill_after_ready: assert property (@(posedge clk) disable iff (!nrst)
        refill |-> $past(ready_l2 && read_l2));

endmodule

// ==== hw/l1i_data_array.sv ====
`timescale 1ns/100ps

module l1i_data_array
    import l1i_pkg::*;
(
    input  logic                  clk,
    input  logic                  nrst,
    input  logic [INDEX_BITS-1:0] set_index,
    input  logic                  way,
    input  logic [3:0]            word_sel,
    input  logic                  refill,
    input  logic [LINE_BITS-1:0]  line_in,
    output logic [31:0]           word_out
);

    localparam int ENTRIES = 2 ** (INDEX_BITS + 1);

    logic [LINE_BITS-1:0] lines [ENTRIES];
    logic [LINE_BITS-1:0] line_rd;

    always_ff @(posedge clk)
    begin
        if (refill)
            lines[{set_index, way}] <= line_in;
    end

    // async read, word ready in the hit cycle
    assign line_rd  = lines[{set_index, way}];
    assign word_out = line_rd[{word_sel, 5'b0} +: 32];

    // one line per miss, so refill never lasts two cycles
    a_refill_pulse: assert property (@(posedge clk) disable iff (!nrst)
        refill |=> !refill);

endmodule

// ==== hw/l2_refill_arbiter.sv ====
`timescale 1ns/100ps

module l2_refill_arbiter
    import l1i_pkg::*;
(
    input  logic                    clk,
    input  logic                    nrst,
    input  logic                    read_l2_0,
    input  logic [L2_ADDR_BITS-1:0] line_addr_0,
    input  logic                    read_l2_1,
    input  logic [L2_ADDR_BITS-1:0] line_addr_1,
    output logic                    ready_l2_0,
    output logic                    ready_l2_1,
    output logic                    mem_read,
    output logic [L2_ADDR_BITS-1:0] mem_line_addr,
    input  logic                    mem_ready
);

    logic busy;
    logic owner;
    logic prio;     // preferred port on a tie

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            busy  <= 1'b0;
            owner <= 1'b0;
            prio  <= 1'b0;
        end
        else if (busy)
        begin
            if (mem_ready)
            begin
                busy <= 1'b0;
                prio <= !owner;     // other port goes first next time
            end
        end
        else if (read_l2_0 || read_l2_1)
        begin
            busy  <= 1'b1;
            owner <= (read_l2_0 && read_l2_1) ? prio : read_l2_1;
        end
    end

    assign mem_read      = busy;
    assign mem_line_addr = owner ? line_addr_1 : line_addr_0;
    assign ready_l2_0    = mem_ready && busy && !owner;
    assign ready_l2_1    = mem_ready && busy && owner;

    // every memory reply goes to exactly one port
    a_one_ready: assert property (@(posedge clk) disable iff (!nrst)
        mem_ready |-> $onehot({ready_l2_1, ready_l2_0}));

endmodule

// ==== hw/l2_backing_mem.sv ====
`timescale 1ns/100ps

module l2_backing_mem
    import l1i_pkg::*;
#(
    parameter int L2_LATENCY = 4
)
(
    input  logic                    clk,
    input  logic                    nrst,
    input  logic                    mem_read,
    input  logic [L2_ADDR_BITS-1:0] mem_line_addr,
    output logic                    mem_ready,
    output logic [LINE_BITS-1:0]    mem_line
);

    localparam int CNT_BITS = (L2_LATENCY > 1) ? $clog2(L2_LATENCY) : 1;

    logic                    busy;
    logic [CNT_BITS-1:0]     count;
    logic [L2_ADDR_BITS-1:0] addr_q;
    logic [LINE_BITS-1:0]    line_img;

    // word w of line a lives at byte address {a, w, 2'b00}
    always_comb
    begin
        for (int w = 0; w < WORDS_PER_LINE; w++)
            line_img[w*32 +: 32] = {addr_q, 4'(w), 2'b00} ^ L2_PATTERN;
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            busy      <= 1'b0;
            count     <= '0;
            mem_ready <= 1'b0;
        end
        else
        begin
            mem_ready <= 1'b0;
            if (!busy)
            begin
                if (mem_read)
                begin
                    busy  <= 1'b1;
                    count <= CNT_BITS'(L2_LATENCY - 1);
                end
            end
            else if (mem_ready)
                busy <= 1'b0;           // stay busy through the ready cycle
            else if (count != '0)
                count <= count - 1'b1;
            else
                mem_ready <= 1'b1;
        end
    end

    // line held until the next reply
    always_ff @(posedge clk)
    begin
        if (!busy && mem_read)
            addr_q <= mem_line_addr;
        if (busy && !mem_ready && (count == '0))
            mem_line <= line_img;
    end

endmodule

// ==== hw/dual_fetch_top.sv ====
`timescale 1ns/100ps

module dual_fetch_top
    import l1i_pkg::*;
#(
    parameter int L2_LATENCY = 4
)
(
    input  logic        clk,
    input  logic        nrst,
    input  logic [31:0] fetch_pc_0,
    input  logic [31:0] fetch_pc_1,
    input  logic        fetch_read_0,
    input  logic        fetch_read_1,
    input  logic        flush_0,
    input  logic        flush_1,
    output logic        stall_0,
    output logic        stall_1,
    output logic [31:0] instr_0,
    output logic [31:0] instr_1,
    output logic        instr_valid_0,
    output logic        instr_valid_1,
    output logic        miss_0,
    output logic        miss_1
);

    logic                     read_l2_0, read_l2_1;
    logic                     ready_l2_0, ready_l2_1;
    logic                     refill_0, refill_1;
    logic                     way_0, way_1;
    logic [L2_TAG_BITS-1:0]   l2_tag_0, l2_tag_1;
    logic [L2_INDEX_BITS-1:0] l2_index_0, l2_index_1;
    logic                     mem_read, mem_ready;
    logic [L2_ADDR_BITS-1:0]  mem_line_addr;
    logic [LINE_BITS-1:0]     mem_line;     // shared by both data arrays

    l1i_controller u_ctrl_0 (
        .clk(clk), .nrst(nrst),
        .fetch_tag(fetch_pc_0[31 -: TAG_BITS]),
        .fetch_index(fetch_pc_0[OFFSET_BITS +: INDEX_BITS]),
        .fetch_read(fetch_read_0), .flush(flush_0), .ready_l2(ready_l2_0),
        .stall(stall_0), .refill(refill_0), .read_l2(read_l2_0),
        .l2_index(l2_index_0), .l2_tag(l2_tag_0), .way(way_0),
        .hit(instr_valid_0), .miss(miss_0));

    l1i_controller u_ctrl_1 (
        .clk(clk), .nrst(nrst),
        .fetch_tag(fetch_pc_1[31 -: TAG_BITS]),
        .fetch_index(fetch_pc_1[OFFSET_BITS +: INDEX_BITS]),
        .fetch_read(fetch_read_1), .flush(flush_1), .ready_l2(ready_l2_1),
        .stall(stall_1), .refill(refill_1), .read_l2(read_l2_1),
        .l2_index(l2_index_1), .l2_tag(l2_tag_1), .way(way_1),
        .hit(instr_valid_1), .miss(miss_1));

    l1i_data_array u_data_0 (
        .clk(clk), .nrst(nrst),
        .set_index(fetch_pc_0[OFFSET_BITS +: INDEX_BITS]), .way(way_0),
        .word_sel(fetch_pc_0[OFFSET_BITS-1:2]), .refill(refill_0),
        .line_in(mem_line), .word_out(instr_0));

    l1i_data_array u_data_1 (
        .clk(clk), .nrst(nrst),
        .set_index(fetch_pc_1[OFFSET_BITS +: INDEX_BITS]), .way(way_1),
        .word_sel(fetch_pc_1[OFFSET_BITS-1:2]), .refill(refill_1),
        .line_in(mem_line), .word_out(instr_1));

    l2_refill_arbiter u_arb (
        .clk(clk), .nrst(nrst),
        .read_l2_0(read_l2_0), .line_addr_0({l2_tag_0, l2_index_0}),
        .read_l2_1(read_l2_1), .line_addr_1({l2_tag_1, l2_index_1}),
        .ready_l2_0(ready_l2_0), .ready_l2_1(ready_l2_1),
        .mem_read(mem_read), .mem_line_addr(mem_line_addr), .mem_ready(mem_ready));

    l2_backing_mem #(.L2_LATENCY(L2_LATENCY)) u_mem (
        .clk(clk), .nrst(nrst),
        .mem_read(mem_read), .mem_line_addr(mem_line_addr),
        .mem_ready(mem_ready), .mem_line(mem_line));

endmodule

// ==== tb/dual_fetch_tb.sv ====
`timescale 1ns/100ps

module dual_fetch_tb
    import l1i_pkg::*;
();

    localparam int L2_LATENCY  = 4;
    localparam int RAND_ROUNDS = 40;
    localparam int NUM_FETCHES = 15 + 2 * RAND_ROUNDS;
    localparam int MAX_CYCLES  = NUM_FETCHES * (L2_LATENCY + 8) + 300;
    localparam int SETS        = 2 ** INDEX_BITS;

    logic        clk;
    logic        nrst;
    logic [31:0] fetch_pc_0, fetch_pc_1;
    logic        fetch_read_0, fetch_read_1;
    logic        flush_0, flush_1;
    logic        stall_0, stall_1;
    logic [31:0] instr_0, instr_1;
    logic        instr_valid_0, instr_valid_1;
    logic        miss_0, miss_1;

    int          errors;
    int          err_mark;
    int          tests_run;
    int          failed_tests;
    int          cycles;
    int          miss_seen [2];
    int          miss_exp [2];
    logic [31:0] lfsr = 32'h259e0e4b;

    // reference two-way LRU cache per port
    logic [TAG_BITS-1:0] m_tag [2][SETS][2];
    logic                m_valid [2][SETS][2];
    logic                m_lru [2][SETS];       // way to replace next

    dual_fetch_top #(.L2_LATENCY(L2_LATENCY)) uut (
        .clk(clk), .nrst(nrst),
        .fetch_pc_0(fetch_pc_0), .fetch_pc_1(fetch_pc_1),
        .fetch_read_0(fetch_read_0), .fetch_read_1(fetch_read_1),
        .flush_0(flush_0), .flush_1(flush_1),
        .stall_0(stall_0), .stall_1(stall_1),
        .instr_0(instr_0), .instr_1(instr_1),
        .instr_valid_0(instr_valid_0), .instr_valid_1(instr_valid_1),
        .miss_0(miss_0), .miss_1(miss_1));

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk)
    begin
        if (nrst && miss_0)
            miss_seen[0]++;
        if (nrst && miss_1)
            miss_seen[1]++;
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles > MAX_CYCLES)
        begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Test failures found");
            $finish;
        end
    end

    // word of the image is its byte address xor the pattern
    a_instr_0: assert property (@(posedge clk) disable iff (!nrst)
        instr_valid_0 |-> (instr_0 == ({fetch_pc_0[31:2], 2'b00} ^ L2_PATTERN)))
    else
    begin
        $display("Mismatch at %0t: port 0 pc %h returned %h", $time,
                 $sampled(fetch_pc_0), $sampled(instr_0));
        errors++;
    end

    a_instr_1: assert property (@(posedge clk) disable iff (!nrst)
        instr_valid_1 |-> (instr_1 == ({fetch_pc_1[31:2], 2'b00} ^ L2_PATTERN)))
    else
    begin
        $display("Mismatch at %0t: port 1 pc %h returned %h", $time,
                 $sampled(fetch_pc_1), $sampled(instr_1));
        errors++;
    end

    // stall rises on a read while idle, falls the cycle after instr_valid
    a_stall_0: assert property (@(posedge clk) disable iff (!nrst)
        stall_0 == ($past(stall_0) ? !$past(instr_valid_0) : $past(fetch_read_0)))
    else
    begin
        $display("Mismatch at %0t: port 0 stall is %b", $time, $sampled(stall_0));
        errors++;
    end

    a_stall_1: assert property (@(posedge clk) disable iff (!nrst)
        stall_1 == ($past(stall_1) ? !$past(instr_valid_1) : $past(fetch_read_1)))
    else
    begin
        $display("Mismatch at %0t: port 1 stall is %b", $time, $sampled(stall_1));
        errors++;
    end

    // 32-bit fibonacci, taps 32 22 2 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
            v = {v[30:0], lfsr_bit()};
        return v;
    endfunction

    function automatic logic [31:0] make_addr(input int tag, input int idx, input int word);
        return {TAG_BITS'(tag), INDEX_BITS'(idx), 4'(word), 2'b00};
    endfunction

    // small pool: 4 tags over 4 sets
    function automatic logic [31:0] rand_addr();
        logic [31:0] tag;
        logic [31:0] idx;
        logic [31:0] word;
        tag  = 32'd100 + lfsr_bits(2);
        idx  = lfsr_bits(2);
        word = lfsr_bits(4);
        return make_addr(int'(tag), int'(idx), int'(word));
    endfunction

    // returns 1 on a miss, invalid way first, then lru
    function automatic logic model_access(input int p, input logic [31:0] addr);
        logic [TAG_BITS-1:0]   tag;
        logic [INDEX_BITS-1:0] idx;
        logic                  w;
        tag = addr[31 -: TAG_BITS];
        idx = addr[OFFSET_BITS +: INDEX_BITS];
        for (int i = 0; i < 2; i++)
        begin
            if (m_valid[p][idx][i] && (m_tag[p][idx][i] == tag))
            begin
                m_lru[p][idx] = (i == 0);
                return 1'b0;
            end
        end
        if (!m_valid[p][idx][0])
            w = 1'b0;
        else if (!m_valid[p][idx][1])
            w = 1'b1;
        else
            w = m_lru[p][idx];
        m_tag[p][idx][w]   = tag;
        m_valid[p][idx][w] = 1'b1;
        m_lru[p][idx]      = !w;
        return 1'b1;
    endfunction

    task automatic fetch(input int p, input logic [31:0] addr);
        @(negedge clk);
        if (model_access(p, addr))
            miss_exp[p]++;
        if (p == 0)
        begin
            fetch_pc_0   = addr;
            fetch_read_0 = 1'b1;
        end
        else
        begin
            fetch_pc_1   = addr;
            fetch_read_1 = 1'b1;
        end
        @(negedge clk);
        while (!((p == 0) ? instr_valid_0 : instr_valid_1))
            @(negedge clk);
        if (p == 0)
            fetch_read_0 = 1'b0;
        else
            fetch_read_1 = 1'b0;
    endtask

    task automatic flush_port(input int p);
        @(negedge clk);
        if (p == 0)
            flush_0 = 1'b1;
        else
            flush_1 = 1'b1;
        @(negedge clk);
        flush_0 = 1'b0;
        flush_1 = 1'b0;
        for (int s = 0; s < SETS; s++)
        begin
            m_valid[p][s][0] = 1'b0;
            m_valid[p][s][1] = 1'b0;    // lru bits survive a flush
        end
    endtask

    task automatic end_test(input string name);
        for (int p = 0; p < 2; p++)
        begin
            assert (miss_seen[p] == miss_exp[p])
            else
            begin
                $display("Mismatch at %0t: port %0d counted %0d misses, model expects %0d",
                         $time, p, miss_seen[p], miss_exp[p]);
                errors++;
            end
        end
        tests_run++;
        if (errors != err_mark)
        begin
            failed_tests++;
            $display("%s: FAIL", name);
        end
        else
            $display("%s: ok", name);
        err_mark = errors;
    endtask

    initial
    begin
        logic [31:0] r0;
        logic [31:0] r1;
        errors       = 0;
        err_mark     = 0;
        tests_run    = 0;
        failed_tests = 0;
        cycles       = 0;
        miss_seen    = '{0, 0};
        miss_exp     = '{0, 0};
        nrst         = 1'b0;
        fetch_pc_0   = '0;
        fetch_pc_1   = '0;
        fetch_read_0 = 1'b0;
        fetch_read_1 = 1'b0;
        flush_0      = 1'b0;
        flush_1      = 1'b0;
        for (int p = 0; p < 2; p++)
        begin
            for (int s = 0; s < SETS; s++)
            begin
                m_valid[p][s][0] = 1'b0;
                m_valid[p][s][1] = 1'b0;
                m_lru[p][s]      = 1'b0;
            end
        end
        repeat (5) @(negedge clk);
        nrst = 1'b1;

        fetch(0, make_addr(1, 3, 4));
        fetch(1, make_addr(2, 4, 11));
        end_test("cold fetch");

        fetch(0, make_addr(1, 3, 7));
        fetch(0, make_addr(1, 3, 0));
        fetch(1, make_addr(2, 4, 15));
        end_test("warm hit");

        // A B A C A B in set 9
        fetch(0, make_addr(10, 9, 1));
        fetch(0, make_addr(11, 9, 2));
        fetch(0, make_addr(10, 9, 3));
        fetch(0, make_addr(12, 9, 4));
        fetch(0, make_addr(10, 9, 5));
        fetch(0, make_addr(11, 9, 6));
        end_test("two-way lru");

        flush_port(0);
        fetch(0, make_addr(1, 3, 2));
        fetch(1, make_addr(2, 4, 1));
        end_test("flush");

        fork
            fetch(0, make_addr(20, 17, 5));
            fetch(1, make_addr(21, 17, 9));
        join
        end_test("concurrent misses");

        for (int i = 0; i < RAND_ROUNDS; i++)
        begin
            r0 = rand_addr();
            r1 = rand_addr();
            fork
                fetch(0, r0);
                fetch(1, r1);
            join
        end
        end_test("random stream");

        $display("tests run %0d, failed %0d, errors %0d", tests_run, failed_tests, errors);
        if (errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

// ==== dual_fetch.f ====
hw/l1i_pkg.sv
hw/l1i_controller.sv
hw/l1i_data_array.sv
hw/l2_refill_arbiter.sv
hw/l2_backing_mem.sv
hw/dual_fetch_top.sv
tb/dual_fetch_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the dual fetch testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/100ps \
    -f dual_fetch.f --top-module dual_fetch_tb -o dual_fetch_sim

./obj_dir/dual_fetch_sim | tee sim.log

if grep -q "Test failures found" sim.log; then
    echo "simulation reported failures, see sim.log"
    exit 1
fi

echo "simulation finished without failures"
exit 0
